//--- hw/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;   // Data word or byte address
   typedef logic [4:0]      reg_addr_t;
   typedef logic [31:0]     instr_t;

   // Major opcodes kept by this core
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } alu_op_e;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src;   // Second operand from the immediate
      alu_op_e alu_op;
   } ctrl_t;

   typedef struct packed {
      logic   valid;
      word_t  pc;
      instr_t instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     rs1_data;
      word_t     rs2_data;
      word_t     imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rd;
      word_t     alu_result;
      word_t     store_data;
   } ex_mem_t;

   // Register write bundle, also the MEM/WB forwarding source
   typedef struct packed {
      logic      reg_write;
      reg_addr_t rd;
      word_t     data;
   } wb_t;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`default_nettype none

module fetch_stage #(
   parameter riscv_pkg::word_t RESET_PC = '0
) (
   input  wire                    clk,
   input  wire                    reset_i,
   input  wire                    stall_i,
   input  riscv_pkg::instr_t      inst_i,
   output riscv_pkg::word_t       inst_addr_o,
   output logic                   inst_ce_o,
   output riscv_pkg::if_id_t      if_id_o
);

   riscv_pkg::word_t  pc_q;
   riscv_pkg::if_id_t if_id_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         pc_q          <= RESET_PC;
         if_id_q.valid <= 1'b0;
      end else if (!stall_i) begin
         pc_q          <= pc_q + riscv_pkg::word_t'(4);
         if_id_q.valid <= 1'b1;
      end
   end

   // Payload of IF/ID, held with the PC during a stall
   always_ff @(posedge clk) begin
      if (!stall_i) begin
         if_id_q.pc    <= pc_q;
         if_id_q.instr <= inst_i;   // Memory answers in the same cycle
      end
   end

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ~reset_i;
   assign if_id_o     = if_id_q;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none

module reg_file (
   input  wire                    clk,
   input  wire                    reset_i,
   input  riscv_pkg::reg_addr_t   rs1_i,
   input  riscv_pkg::reg_addr_t   rs2_i,
   input  riscv_pkg::wb_t         wb_i,
   output riscv_pkg::word_t       rs1_data_o,
   output riscv_pkg::word_t       rs2_data_o
);

   riscv_pkg::word_t regs_q [1:31];   // No storage for x0

   function automatic riscv_pkg::word_t read_port(riscv_pkg::reg_addr_t addr);
      riscv_pkg::word_t value;
      if (addr == '0) begin
         value = '0;
      end else if (wb_i.reg_write && wb_i.rd == addr) begin
         value = wb_i.data;   // Write-through bypass
      end else begin
         value = regs_q[addr];
      end
      return value;
   endfunction

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 1; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wb_i.reg_write && wb_i.rd != '0) begin
         regs_q[wb_i.rd] <= wb_i.data;
      end
   end

   assign rs1_data_o = read_port(rs1_i);
   assign rs2_data_o = read_port(rs2_i);

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`default_nettype none

module decode_stage (
   input  wire                    clk,
   input  wire                    reset_i,
   input  riscv_pkg::if_id_t      if_id_i,
   input  riscv_pkg::wb_t         wb_i,
   output riscv_pkg::id_ex_t      id_ex_o,
   output logic                   stall_o
);

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_LW  = 3'b010;

   riscv_pkg::instr_t    instr;
   logic [6:0]           opcode;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   riscv_pkg::reg_addr_t rs1;
   riscv_pkg::reg_addr_t rs2;
   riscv_pkg::reg_addr_t rd;
   riscv_pkg::word_t     rs1_data;
   riscv_pkg::word_t     rs2_data;
   riscv_pkg::word_t     imm;
   riscv_pkg::ctrl_t     ctrl_d;
   logic                 legal;
   logic                 uses_rs1;
   logic                 uses_rs2;
   logic                 stall;
   logic                 bubble;
   riscv_pkg::id_ex_t    id_ex_q;

   assign instr  = if_id_i.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];

   reg_file reg_file_i (
      .clk        (clk),
      .reset_i    (reset_i),
      .rs1_i      (rs1),
      .rs2_i      (rs2),
      .wb_i       (wb_i),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   always_comb begin
      ctrl_d        = '0;
      ctrl_d.alu_op = riscv_pkg::ALU_ADD;
      imm           = {{20{instr[31]}}, instr[31:20]};   // I-type by default
      legal         = 1'b0;
      uses_rs1      = 1'b0;
      uses_rs2      = 1'b0;
      case (opcode)
         riscv_pkg::OPC_OP: begin
            ctrl_d.reg_write = 1'b1;
            uses_rs1         = 1'b1;
            uses_rs2         = 1'b1;
            legal            = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == F3_ADD);
            case (funct3)
               F3_ADD:  ctrl_d.alu_op = funct7[5] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
               F3_SLT:  ctrl_d.alu_op = riscv_pkg::ALU_SLT;
               F3_XOR:  ctrl_d.alu_op = riscv_pkg::ALU_XOR;
               F3_OR:   ctrl_d.alu_op = riscv_pkg::ALU_OR;
               F3_AND:  ctrl_d.alu_op = riscv_pkg::ALU_AND;
               default: legal = 1'b0;
            endcase
         end
         riscv_pkg::OPC_OP_IMM: begin
            ctrl_d.reg_write = 1'b1;
            ctrl_d.alu_src   = 1'b1;
            uses_rs1         = 1'b1;
            legal            = 1'b1;
            case (funct3)
               F3_ADD:  ctrl_d.alu_op = riscv_pkg::ALU_ADD;
               F3_XOR:  ctrl_d.alu_op = riscv_pkg::ALU_XOR;
               F3_OR:   ctrl_d.alu_op = riscv_pkg::ALU_OR;
               F3_AND:  ctrl_d.alu_op = riscv_pkg::ALU_AND;
               default: legal = 1'b0;
            endcase
         end
         riscv_pkg::OPC_LOAD: begin
            ctrl_d.reg_write = 1'b1;
            ctrl_d.mem_read  = 1'b1;
            ctrl_d.alu_src   = 1'b1;
            uses_rs1         = 1'b1;
            legal            = (funct3 == F3_LW);   // Word loads only
         end
         riscv_pkg::OPC_STORE: begin
            ctrl_d.mem_write = 1'b1;
            ctrl_d.alu_src   = 1'b1;
            imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            uses_rs1         = 1'b1;
            uses_rs2         = 1'b1;
            legal            = (funct3 == F3_LW);
         end
         default: legal = 1'b0;   // Unsupported opcode becomes a bubble
      endcase
   end

   // Load in ID/EX whose result the decoding instruction needs
   assign stall = if_id_i.valid && id_ex_q.ctrl.mem_read && id_ex_q.rd != '0 &&
                  ((uses_rs1 && id_ex_q.rd == rs1) || (uses_rs2 && id_ex_q.rd == rs2));

   assign bubble = stall || !if_id_i.valid || !legal;

   always_ff @(posedge clk) begin
      if (reset_i || bubble) begin
         id_ex_q.ctrl <= '0;
      end else begin
         id_ex_q.ctrl <= ctrl_d;
      end
      id_ex_q.rs1      <= rs1;
      id_ex_q.rs2      <= rs2;
      id_ex_q.rd       <= rd;
      id_ex_q.rs1_data <= rs1_data;
      id_ex_q.rs2_data <= rs2_data;
      id_ex_q.imm      <= imm;
   end

   assign id_ex_o = id_ex_q;
   assign stall_o = stall;

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`default_nettype none

module execute_stage (
   input  wire                    clk,
   input  wire                    reset_i,
   input  riscv_pkg::id_ex_t      id_ex_i,
   input  riscv_pkg::wb_t         wb_i,
   output riscv_pkg::ex_mem_t     ex_mem_o
);

   riscv_pkg::ex_mem_t ex_mem_q;
   riscv_pkg::wb_t     ex_fwd;      // EX/MEM result as seen by forwarding
   logic               ex_load;
   riscv_pkg::word_t   op_a;
   riscv_pkg::word_t   rs2_fwd;
   riscv_pkg::word_t   op_b;
   riscv_pkg::word_t   alu_result;

   // EX/MEM first, then MEM/WB, then the value read in decode
   function automatic riscv_pkg::word_t forward(
      riscv_pkg::reg_addr_t rs,
      riscv_pkg::word_t     reg_data,
      riscv_pkg::wb_t       ex_v,
      logic                 ex_is_load,
      riscv_pkg::wb_t       wb_v
   );
      riscv_pkg::word_t value;
      if (ex_v.reg_write && !ex_is_load && ex_v.rd != '0 && ex_v.rd == rs) begin
         value = ex_v.data;
      end else if (wb_v.reg_write && wb_v.rd != '0 && wb_v.rd == rs) begin
         value = wb_v.data;
      end else begin
         value = reg_data;
      end
      return value;
   endfunction

   assign ex_fwd.reg_write = ex_mem_q.ctrl.reg_write;
   assign ex_fwd.rd        = ex_mem_q.rd;
   assign ex_fwd.data      = ex_mem_q.alu_result;
   assign ex_load          = ex_mem_q.ctrl.mem_read;   // Load data not ready yet

   assign op_a    = forward(id_ex_i.rs1, id_ex_i.rs1_data, ex_fwd, ex_load, wb_i);
   assign rs2_fwd = forward(id_ex_i.rs2, id_ex_i.rs2_data, ex_fwd, ex_load, wb_i);
   assign op_b    = id_ex_i.ctrl.alu_src ? id_ex_i.imm : rs2_fwd;

   always_comb begin
      case (id_ex_i.ctrl.alu_op)
         riscv_pkg::ALU_ADD: alu_result = op_a + op_b;   // Also address of lw and sw
         riscv_pkg::ALU_SUB: alu_result = op_a - op_b;
         riscv_pkg::ALU_AND: alu_result = op_a & op_b;
         riscv_pkg::ALU_OR:  alu_result = op_a | op_b;
         riscv_pkg::ALU_XOR: alu_result = op_a ^ op_b;
         riscv_pkg::ALU_SLT: begin
            alu_result = {{(riscv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         end
         default: alu_result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ex_mem_q.ctrl <= '0;
      end else begin
         ex_mem_q.ctrl <= id_ex_i.ctrl;
      end
      ex_mem_q.rd         <= id_ex_i.rd;
      ex_mem_q.alu_result <= alu_result;
      ex_mem_q.store_data <= rs2_fwd;   // Forwarded, so sw sees fresh data
   end

   assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
   input  wire                    clk,
   input  wire                    reset_i,
   input  riscv_pkg::ex_mem_t     ex_mem_i,
   input  riscv_pkg::word_t       data_i,
   output riscv_pkg::word_t       data_addr_o,
   output riscv_pkg::word_t       data_o,
   output logic                   data_ce_o,
   output logic                   data_we_o,
   output riscv_pkg::wb_t         wb_o
);

   riscv_pkg::wb_t   mem_wb_q;
   riscv_pkg::word_t result;

   // Request straight from EX/MEM, memory answers this cycle
   assign data_addr_o = ex_mem_i.alu_result;
   assign data_o      = ex_mem_i.store_data;
   assign data_ce_o   = ex_mem_i.ctrl.mem_read | ex_mem_i.ctrl.mem_write;
   assign data_we_o   = ex_mem_i.ctrl.mem_write;

   assign result = ex_mem_i.ctrl.mem_read ? data_i : ex_mem_i.alu_result;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         mem_wb_q.reg_write <= 1'b0;
      end else begin
         mem_wb_q.reg_write <= ex_mem_i.ctrl.reg_write;
      end
      mem_wb_q.rd   <= ex_mem_i.rd;
      mem_wb_q.data <= result;
   end

   assign wb_o = mem_wb_q;

endmodule

`default_nettype wire

//--- hw/riscv_core.sv
`default_nettype none

module riscv_core #(
   parameter riscv_pkg::word_t RESET_PC = '0
) (
   input  wire                    clk,
   input  wire                    reset_i,   // Synchronous, active high

   // Instruction memory
   input  riscv_pkg::instr_t      inst_i,
   output riscv_pkg::word_t       inst_addr_o,
   output logic                   inst_ce_o,

   // Data memory
   input  riscv_pkg::word_t       data_i,
   output logic                   data_we_o,
   output logic                   data_ce_o,
   output riscv_pkg::word_t       data_addr_o,
   output riscv_pkg::word_t       data_o
);

   riscv_pkg::if_id_t  if_id;
   riscv_pkg::id_ex_t  id_ex;
   riscv_pkg::ex_mem_t ex_mem;
   riscv_pkg::wb_t     wb;
   logic               stall;

   fetch_stage #(
      .RESET_PC (RESET_PC)
   ) fetch_stage_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .stall_i     (stall),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .if_id_o     (if_id)
   );

   decode_stage decode_stage_i (
      .clk     (clk),
      .reset_i (reset_i),
      .if_id_i (if_id),
      .wb_i    (wb),
      .id_ex_o (id_ex),
      .stall_o (stall)
   );

   execute_stage execute_stage_i (
      .clk      (clk),
      .reset_i  (reset_i),
      .id_ex_i  (id_ex),
      .wb_i     (wb),        // MEM/WB forwarding
      .ex_mem_o (ex_mem)
   );

   mem_wb_stage mem_wb_stage_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .ex_mem_i    (ex_mem),
      .data_i      (data_i),
      .data_addr_o (data_addr_o),
      .data_o      (data_o),
      .data_ce_o   (data_ce_o),
      .data_we_o   (data_we_o),
      .wb_o        (wb)
   );

endmodule

`default_nettype wire

//--- tests/riscv_core_sva.sv
`default_nettype none

module riscv_core_sva #(
   parameter riscv_pkg::word_t RESET_PC = '0
) (
   input wire              clk,
   input wire              reset_i,
   input riscv_pkg::word_t inst_addr_o,
   input wire              inst_ce_o,
   input wire              data_ce_o,
   input wire              data_we_o
);

   // Ports quiet and PC parked through the first cycle after reset
   reset_quiet: assert property (@(posedge clk)
      reset_i |=> !data_ce_o && !data_we_o && inst_addr_o == RESET_PC)
      else $error("Data port active or PC off its reset value around reset");

   fetch_off_in_reset: assert property (@(posedge clk) reset_i |-> !inst_ce_o)
      else $error("Instruction fetch enabled during reset");

   fetch_on_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> inst_ce_o)
      else $error("Instruction fetch not enabled in the first cycle after reset");

   pc_step: assert property (@(posedge clk)
      !reset_i && $past(!reset_i) |->
         inst_addr_o == $past(inst_addr_o) || inst_addr_o == $past(inst_addr_o) + 32'd4)
      else $error("PC neither held nor advanced by four");

   // A load-use stall lasts a single cycle
   single_hold: assert property (@(posedge clk)
      !reset_i && $past(!reset_i) && inst_addr_o == $past(inst_addr_o) |=>
         inst_addr_o != $past(inst_addr_o))
      else $error("PC held for two cycles in a row");

   write_has_enable: assert property (@(posedge clk) data_we_o |-> data_ce_o)
      else $error("Data write strobe without chip enable");

endmodule

bind riscv_core riscv_core_sva #(
   .RESET_PC (RESET_PC)
) riscv_core_sva_i (
   .clk         (clk),
   .reset_i     (reset_i),
   .inst_addr_o (inst_addr_o),
   .inst_ce_o   (inst_ce_o),
   .data_ce_o   (data_ce_o),
   .data_we_o   (data_we_o)
);

`default_nettype wire

//--- tests/riscv_core_tb.sv
`default_nettype none

module riscv_core_tb;

   localparam riscv_pkg::word_t  RESET_PC = '0;
   localparam riscv_pkg::instr_t NOP      = 32'h0000_0013;   // addi x0, x0, 0
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   logic              clk;
   logic              reset_i;
   riscv_pkg::instr_t inst_i;
   riscv_pkg::word_t  inst_addr_o;
   logic              inst_ce_o;
   riscv_pkg::word_t  data_i;
   logic              data_we_o;
   logic              data_ce_o;
   riscv_pkg::word_t  data_addr_o;
   riscv_pkg::word_t  data_o;

   riscv_pkg::instr_t imem [256];
   riscv_pkg::word_t  dmem [256];
   riscv_pkg::word_t  xr [32];        // Register values as the program leaves them
   riscv_pkg::word_t  exp_addr [$];
   riscv_pkg::word_t  exp_data [$];
   int                prog_len;
   int                lw_pc;
   int                total_stores;
   int                stores_seen;
   int                errors;
   int                holds;
   logic              past_valid;
   riscv_pkg::word_t  prev_addr;

   riscv_core #(
      .RESET_PC (RESET_PC)
   ) riscv_core_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .data_i      (data_i),
      .data_we_o   (data_we_o),
      .data_ce_o   (data_ce_o),
      .data_addr_o (data_addr_o),
      .data_o      (data_o)
   );

   always #10 clk = ~clk;

   function automatic riscv_pkg::word_t fill_word(riscv_pkg::word_t addr);
      return 32'h6B1D_0000 ^ addr ^ (addr << 16);
   endfunction

   function automatic riscv_pkg::word_t sext12(logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   // RV32I result of the kept ALU operations
   function automatic riscv_pkg::word_t alu_rule(logic [2:0] f3, logic sub,
                                                 riscv_pkg::word_t a, riscv_pkg::word_t b);
      case (f3)
         F3_ADD:  return sub ? a - b : a + b;
         F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
         F3_XOR:  return a ^ b;
         F3_OR:   return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic rr_op(logic [2:0] f3, logic sub, int rd, int rs1, int rs2);
      imem[prog_len] = {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), riscv_pkg::OPC_OP};
      prog_len++;
      xr[rd] = alu_rule(f3, sub, xr[rs1], xr[rs2]);
   endtask

   task automatic imm_op(logic [2:0] f3, int rd, int rs1, logic [11:0] imm);
      imem[prog_len] = {imm, 5'(rs1), f3, 5'(rd), riscv_pkg::OPC_OP_IMM};
      prog_len++;
      if (rd != 0) begin
         xr[rd] = alu_rule(f3, 1'b0, xr[rs1], sext12(imm));   // x0 stays zero
      end
   endtask

   task automatic load_word(int rd, int rs1, logic [11:0] imm);
      lw_pc          = prog_len * 4;
      imem[prog_len] = {imm, 5'(rs1), 3'b010, 5'(rd), riscv_pkg::OPC_LOAD};
      prog_len++;
      xr[rd] = fill_word(xr[rs1] + sext12(imm));   // Address never stored to
   endtask

   task automatic store_word(int rs2, int rs1, logic [11:0] imm);
      imem[prog_len] = {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], riscv_pkg::OPC_STORE};
      prog_len++;
      exp_addr.push_back(xr[rs1] + sext12(imm));
      exp_data.push_back(xr[rs2]);
   endtask

   // Both memories answer in the request cycle
   assign inst_i = (inst_addr_o < 32'd1024) ? imem[inst_addr_o[9:2]] : NOP;
   assign data_i = data_ce_o ? dmem[data_addr_o[9:2]] : '0;   // Read data only on an access

   always @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(riscv_pkg::word_t'(i * 4));
         end
      end else if (data_we_o) begin
         dmem[data_addr_o[9:2]] <= data_o;
      end
   end

   // Store order and values, and where the fetch address holds
   always @(posedge clk) begin
      if (reset_i) begin
         errors      = 0;
         stores_seen = 0;
         holds       = 0;
         past_valid  = 1'b0;
      end else begin
         if (data_we_o && stores_seen >= total_stores) begin
            errors++;
            $display("Store to %h arrived after the last expected store", data_addr_o);
         end else if (data_we_o) begin
            assert (data_addr_o == exp_addr[stores_seen]) else begin
               errors++;
               $display("** Error @ %0t: store %0d address expected %h, got %h", $time,
                        stores_seen, exp_addr[stores_seen], data_addr_o);
            end
            assert (data_o == exp_data[stores_seen]) else begin
               errors++;
               $display("** Error @ %0t: store %0d data expected %h, got %h", $time,
                        stores_seen, exp_data[stores_seen], data_o);
            end
            stores_seen++;
         end
         if (past_valid && inst_addr_o == prev_addr) begin
            holds++;
            assert (inst_addr_o == riscv_pkg::word_t'(lw_pc + 8)) else begin
               errors++;
               $display("** Error @ %0t: fetch held at %h, expected hold at %h", $time,
                        inst_addr_o, lw_pc + 8);
            end
         end
         past_valid = 1'b1;
      end
      prev_addr = inst_addr_o;
   end

   initial begin
      logic [11:0] k [5];
      int          fails;
      clk          = 1'b0;
      reset_i     <= 1'b1;
      prog_len     = 0;
      total_stores = 0;
      void'($urandom(1770));
      for (int i = 0; i < 5; i++) begin
         k[i] = 12'($urandom);
      end
      for (int i = 0; i < 256; i++) begin
         imem[i] = NOP;
      end
      for (int i = 0; i < 32; i++) begin
         xr[i] = '0;
      end
      imm_op(F3_ADD, 12, 0, 12'h100);      // Store base
      imm_op(F3_ADD, 1, 0, k[0]);
      imm_op(F3_OR, 2, 0, k[1]);
      rr_op(F3_ADD, 1'b0, 3, 1, 2);        // Distances 2 and 1
      rr_op(F3_ADD, 1'b1, 4, 3, 1);        // sub, x1 at distance 3
      store_word(3, 12, 12'h000);
      rr_op(F3_AND, 1'b0, 5, 4, 2);
      store_word(5, 12, 12'h004);          // Store data from EX/MEM
      rr_op(F3_OR, 1'b0, 6, 5, 3);
      rr_op(F3_XOR, 1'b0, 7, 6, 4);
      rr_op(F3_SLT, 1'b0, 8, 7, 1);
      store_word(4, 12, 12'h008);
      store_word(6, 12, 12'h00C);
      store_word(7, 12, 12'h010);
      store_word(8, 12, 12'h014);
      imm_op(F3_XOR, 9, 8, k[2]);
      imm_op(F3_AND, 10, 7, k[3]);
      imm_op(F3_ADD, 11, 9, k[4]);
      store_word(9, 12, 12'hFFC);          // Negative offsets
      store_word(10, 12, 12'hFF8);
      store_word(11, 12, 12'hFF4);
      load_word(13, 12, 12'h100);
      rr_op(F3_ADD, 1'b0, 14, 13, 2);      // Load-use
      store_word(14, 12, 12'h018);
      imm_op(F3_ADD, 0, 1, 12'h055);
      store_word(0, 12, 12'hFF0);
      total_stores = exp_addr.size();
      repeat (16) @(posedge clk);
      reset_i <= 1'b0;
      wait (stores_seen == total_stores);
      repeat (4) @(posedge clk);           // Instructions still in flight
      fails = errors;
      assert (holds == 1) else begin
         fails++;
         $display("** Error @ %0t: fetch held %0d times, expected one load-use stall", $time,
                  holds);
      end
      $display("Errors: %0d, stores checked: %0d of %0d", fails, stores_seen, total_stores);
      if (fails == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      wait (total_stores != 0);
      repeat (16 + prog_len * 4 + 100) @(posedge clk);
      $display("Timeout: %0d of %0d stores seen before the watchdog expired",
               stores_seen, total_stores);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
hw/riscv_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/riscv_core.sv
tests/riscv_core_sva.sv
tests/riscv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
RTL_TOP   ?= riscv_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
SIM_FLAGS ?= --binary --assert --timing

RTL_SRCS := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "FAIL: pass line missing in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
